// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= shr_tb
RTL_TOP    ?= shr_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ns
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/shr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module shr_arbiter #(
    parameter int RAM_AW = 11
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               sub_block,
    // Main CPU port
    input  wire logic               main_req,
    input  wire logic               main_we,
    input  wire shr_bus_pkg::addr_t main_addr,
    input  wire shr_bus_pkg::data_t main_wdata,
    output logic                    main_ack,
    output shr_bus_pkg::data_t      main_rdata,
    // Sub CPU port
    input  wire logic               sub_req,
    input  wire logic               sub_we,
    input  wire shr_bus_pkg::addr_t sub_addr,
    input  wire shr_bus_pkg::data_t sub_wdata,
    output logic                    sub_ack,
    output shr_bus_pkg::data_t      sub_rdata,
    // Shared RAM
    output logic                    ram_en,
    output logic                    ram_we,
    output logic [RAM_AW-1:0]       ram_addr,
    output shr_bus_pkg::data_t      ram_wdata,
    input  wire shr_bus_pkg::data_t ram_rdata
);

shr_ctrl_pkg::arb_state_e state;
shr_ctrl_pkg::owner_e     last_owner;

logic               sub_ok;
logic               pick_sub;
logic               grant;
shr_bus_pkg::addr_t grant_addr;

// Main side can lock the sub CPU out
assign sub_ok = sub_req && !sub_block;

// On a tie the port not served last wins
assign pick_sub = sub_ok && (!main_req || (last_owner == shr_ctrl_pkg::MAIN));
assign grant    = (state == shr_ctrl_pkg::ARB_IDLE) && (main_req || sub_ok);

assign grant_addr = pick_sub ? sub_addr : main_addr;

assign ram_en    = grant;
assign ram_we    = grant && (pick_sub ? sub_we : main_we);
assign ram_addr  = grant_addr[RAM_AW-1:0];
assign ram_wdata = pick_sub ? sub_wdata : main_wdata;

// RAM data is valid in the ack cycle only
assign main_ack   = (state == shr_ctrl_pkg::ARB_ACK) && (last_owner == shr_ctrl_pkg::MAIN);
assign sub_ack    = (state == shr_ctrl_pkg::ARB_ACK) && (last_owner == shr_ctrl_pkg::SUB);
assign main_rdata = ram_rdata;
assign sub_rdata  = ram_rdata;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state      <= shr_ctrl_pkg::ARB_IDLE;
        last_owner <= shr_ctrl_pkg::SUB;
    end else begin
        case (state)
            shr_ctrl_pkg::ARB_IDLE: begin
                if (grant) begin
                    state <= shr_ctrl_pkg::ARB_ACK;
                    if (pick_sub) begin
                        last_owner <= shr_ctrl_pkg::SUB;
                    end else begin
                        last_owner <= shr_ctrl_pkg::MAIN;
                    end
                end
            end
            default: begin
                state <= shr_ctrl_pkg::ARB_IDLE;
            end
        endcase
    end
end

endmodule

`default_nettype wire

// ==== source/shr_axil_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module shr_axil_port #(
    parameter int RAM_AW = 11
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // Write address and data
    input  wire shr_bus_pkg::addr_t awaddr,
    input  wire logic               awvalid,
    output logic                    awready,
    input  wire shr_bus_pkg::data_t wdata,
    input  wire logic               wvalid,
    output logic                    wready,
    // Write response
    output shr_bus_pkg::resp_t      bresp,
    output logic                    bvalid,
    input  wire logic               bready,
    // Read address
    input  wire shr_bus_pkg::addr_t araddr,
    input  wire logic               arvalid,
    output logic                    arready,
    // Read data
    output shr_bus_pkg::data_t      rdata,
    output shr_bus_pkg::resp_t      rresp,
    output logic                    rvalid,
    input  wire logic               rready,
    // Towards the arbiter
    output logic                    arb_req,
    output logic                    arb_we,
    output shr_bus_pkg::addr_t      arb_addr,
    output shr_bus_pkg::data_t      arb_wdata,
    input  wire logic               arb_ack,
    input  wire shr_bus_pkg::data_t arb_rdata
);

shr_ctrl_pkg::port_state_e state;

logic               wr_accept;
logic               rd_accept;
logic               accept;
logic               in_range;
logic               resp_done;
shr_bus_pkg::addr_t acc_addr;
shr_bus_pkg::data_t rdata_q;
shr_bus_pkg::resp_t resp_q;

// Write wins when both are valid; it needs address and data together
assign wr_accept = (state == shr_ctrl_pkg::IDLE) && awvalid && wvalid;
assign rd_accept = (state == shr_ctrl_pkg::IDLE) && arvalid && !(awvalid && wvalid);
assign accept    = wr_accept || rd_accept;

assign acc_addr = wr_accept ? awaddr : araddr;
// Upper address bits must be clear to hit the RAM
assign in_range = (acc_addr >> RAM_AW) == '0;

assign awready = wr_accept;
assign wready  = wr_accept;
assign arready = rd_accept;

assign arb_req = (state == shr_ctrl_pkg::REQ);

assign bvalid    = (state == shr_ctrl_pkg::RESP) && arb_we;
assign rvalid    = (state == shr_ctrl_pkg::RESP) && !arb_we;
assign bresp     = resp_q;
assign rresp     = resp_q;
assign rdata     = rdata_q;
assign resp_done = (bvalid && bready) || (rvalid && rready);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= shr_ctrl_pkg::IDLE;
    end else begin
        case (state)
            shr_ctrl_pkg::IDLE: begin
                if (accept) begin
                    // Out of range goes straight to the error response
                    if (in_range) begin
                        state <= shr_ctrl_pkg::REQ;
                    end else begin
                        state <= shr_ctrl_pkg::RESP;
                    end
                end
            end
            shr_ctrl_pkg::REQ: begin
                if (arb_ack) begin
                    state <= shr_ctrl_pkg::RESP;
                end
            end
            shr_ctrl_pkg::RESP: begin
                if (resp_done) begin
                    state <= shr_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state <= shr_ctrl_pkg::IDLE;
            end
        endcase
    end
end

// Transaction payload held until the response is taken
always_ff @(posedge clk) begin
    if (accept) begin
        arb_we    <= wr_accept;
        arb_addr  <= acc_addr;
        arb_wdata <= wdata;
        rdata_q   <= '0;
        if (in_range) begin
            resp_q <= shr_bus_pkg::RESP_OKAY;
        end else begin
            resp_q <= shr_bus_pkg::RESP_SLVERR;
        end
    end else if ((state == shr_ctrl_pkg::REQ) && arb_ack && !arb_we) begin
        rdata_q <= arb_rdata;
    end
end

endmodule

`default_nettype wire

// ==== source/shr_bus_pkg.sv ====
`default_nettype none

package shr_bus_pkg;

// Byte bus of the CPUs with the 13-bit address decoded on the board
localparam int ADDR_W = 13;
localparam int DATA_W = 8;

typedef logic [ADDR_W-1:0] addr_t;
typedef logic [DATA_W-1:0] data_t;

// AXI response field
typedef logic [1:0] resp_t;

localparam resp_t RESP_OKAY   = 2'b00;
localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== source/shr_ctrl_pkg.sv ====
`default_nettype none

package shr_ctrl_pkg;

// One transaction in flight per CPU port
typedef enum logic [1:0] { IDLE, REQ, RESP } port_state_e;

// Arbiter drives the RAM, then returns ack a cycle later
typedef enum logic { ARB_IDLE, ARB_ACK } arb_state_e;

// Requester id that also records the last grant for round robin
typedef enum logic { MAIN, SUB } owner_e;

endpackage

`default_nettype wire

// ==== source/shr_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module shr_ram #(
    parameter int RAM_AW = 11
) (
    input  wire logic               clk,
    input  wire logic               en,
    input  wire logic               we,
    input  wire logic [RAM_AW-1:0]  addr,
    input  wire shr_bus_pkg::data_t wdata,
    output shr_bus_pkg::data_t      rdata
);

shr_bus_pkg::data_t mem [2**RAM_AW];

// Read first so a write returns the old byte
always_ff @(posedge clk) begin
    if (en) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end
end

endmodule

`default_nettype wire

// ==== source/shr_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module shr_top #(
    parameter int RAM_AW = 11
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               sub_block,
    // Main CPU
    input  wire shr_bus_pkg::addr_t main_awaddr,
    input  wire logic               main_awvalid,
    output logic                    main_awready,
    input  wire shr_bus_pkg::data_t main_wdata,
    input  wire logic               main_wvalid,
    output logic                    main_wready,
    output shr_bus_pkg::resp_t      main_bresp,
    output logic                    main_bvalid,
    input  wire logic               main_bready,
    input  wire shr_bus_pkg::addr_t main_araddr,
    input  wire logic               main_arvalid,
    output logic                    main_arready,
    output shr_bus_pkg::data_t      main_rdata,
    output shr_bus_pkg::resp_t      main_rresp,
    output logic                    main_rvalid,
    input  wire logic               main_rready,
    // Sub CPU
    input  wire shr_bus_pkg::addr_t sub_awaddr,
    input  wire logic               sub_awvalid,
    output logic                    sub_awready,
    input  wire shr_bus_pkg::data_t sub_wdata,
    input  wire logic               sub_wvalid,
    output logic                    sub_wready,
    output shr_bus_pkg::resp_t      sub_bresp,
    output logic                    sub_bvalid,
    input  wire logic               sub_bready,
    input  wire shr_bus_pkg::addr_t sub_araddr,
    input  wire logic               sub_arvalid,
    output logic                    sub_arready,
    output shr_bus_pkg::data_t      sub_rdata,
    output shr_bus_pkg::resp_t      sub_rresp,
    output logic                    sub_rvalid,
    input  wire logic               sub_rready
);

logic               main_arb_req, main_arb_we, main_arb_ack;
shr_bus_pkg::addr_t main_arb_addr;
shr_bus_pkg::data_t main_arb_wdata, main_arb_rdata;

logic               sub_arb_req, sub_arb_we, sub_arb_ack;
shr_bus_pkg::addr_t sub_arb_addr;
shr_bus_pkg::data_t sub_arb_wdata, sub_arb_rdata;

logic               ram_en, ram_we;
logic [RAM_AW-1:0]  ram_addr;
shr_bus_pkg::data_t ram_wdata, ram_rdata;

shr_axil_port #(.RAM_AW(RAM_AW)) u_main_port (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .awaddr     ( main_awaddr    ),
    .awvalid    ( main_awvalid   ),
    .awready    ( main_awready   ),
    .wdata      ( main_wdata     ),
    .wvalid     ( main_wvalid    ),
    .wready     ( main_wready    ),
    .bresp      ( main_bresp     ),
    .bvalid     ( main_bvalid    ),
    .bready     ( main_bready    ),
    .araddr     ( main_araddr    ),
    .arvalid    ( main_arvalid   ),
    .arready    ( main_arready   ),
    .rdata      ( main_rdata     ),
    .rresp      ( main_rresp     ),
    .rvalid     ( main_rvalid    ),
    .rready     ( main_rready    ),
    .arb_req    ( main_arb_req   ),
    .arb_we     ( main_arb_we    ),
    .arb_addr   ( main_arb_addr  ),
    .arb_wdata  ( main_arb_wdata ),
    .arb_ack    ( main_arb_ack   ),
    .arb_rdata  ( main_arb_rdata )
);

shr_axil_port #(.RAM_AW(RAM_AW)) u_sub_port (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .awaddr     ( sub_awaddr     ),
    .awvalid    ( sub_awvalid    ),
    .awready    ( sub_awready    ),
    .wdata      ( sub_wdata      ),
    .wvalid     ( sub_wvalid     ),
    .wready     ( sub_wready     ),
    .bresp      ( sub_bresp      ),
    .bvalid     ( sub_bvalid     ),
    .bready     ( sub_bready     ),
    .araddr     ( sub_araddr     ),
    .arvalid    ( sub_arvalid    ),
    .arready    ( sub_arready    ),
    .rdata      ( sub_rdata      ),
    .rresp      ( sub_rresp      ),
    .rvalid     ( sub_rvalid     ),
    .rready     ( sub_rready     ),
    .arb_req    ( sub_arb_req    ),
    .arb_we     ( sub_arb_we     ),
    .arb_addr   ( sub_arb_addr   ),
    .arb_wdata  ( sub_arb_wdata  ),
    .arb_ack    ( sub_arb_ack    ),
    .arb_rdata  ( sub_arb_rdata  )
);

shr_arbiter #(.RAM_AW(RAM_AW)) u_arbiter (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .sub_block  ( sub_block      ),
    .main_req   ( main_arb_req   ),
    .main_we    ( main_arb_we    ),
    .main_addr  ( main_arb_addr  ),
    .main_wdata ( main_arb_wdata ),
    .main_ack   ( main_arb_ack   ),
    .main_rdata ( main_arb_rdata ),
    .sub_req    ( sub_arb_req    ),
    .sub_we     ( sub_arb_we     ),
    .sub_addr   ( sub_arb_addr   ),
    .sub_wdata  ( sub_arb_wdata  ),
    .sub_ack    ( sub_arb_ack    ),
    .sub_rdata  ( sub_arb_rdata  ),
    .ram_en     ( ram_en         ),
    .ram_we     ( ram_we         ),
    .ram_addr   ( ram_addr       ),
    .ram_wdata  ( ram_wdata      ),
    .ram_rdata  ( ram_rdata      )
);

shr_ram #(.RAM_AW(RAM_AW)) u_ram (
    .clk        ( clk            ),
    .en         ( ram_en         ),
    .we         ( ram_we         ),
    .addr       ( ram_addr       ),
    .wdata      ( ram_wdata      ),
    .rdata      ( ram_rdata      )
);

endmodule

`default_nettype wire

// ==== tb/shr_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module shr_tb;

localparam int RAM_AW  = 11;
localparam int MAX_VEC = 64;

logic clk;
logic rst_n;
logic sub_block;

shr_bus_pkg::addr_t main_awaddr, main_araddr;
shr_bus_pkg::data_t main_wdata, main_rdata;
shr_bus_pkg::resp_t main_bresp, main_rresp;
logic main_awvalid, main_awready, main_wvalid, main_wready, main_bvalid, main_bready;
logic main_arvalid, main_arready, main_rvalid, main_rready;

shr_bus_pkg::addr_t sub_awaddr, sub_araddr;
shr_bus_pkg::data_t sub_wdata, sub_rdata;
shr_bus_pkg::resp_t sub_bresp, sub_rresp;
logic sub_awvalid, sub_awready, sub_wvalid, sub_wready, sub_bvalid, sub_bready;
logic sub_arvalid, sub_arready, sub_rvalid, sub_rready;

// Vector table with port 0 for main, 1 for sub and 2 for both
int                 v_port  [MAX_VEC];
bit                 v_wr    [MAX_VEC];
shr_bus_pkg::addr_t v_addr  [MAX_VEC];
shr_bus_pkg::data_t v_wdata [MAX_VEC];
shr_bus_pkg::data_t v_exp   [MAX_VEC];
shr_bus_pkg::resp_t v_resp  [MAX_VEC];
bit                 v_blk   [MAX_VEC];

int     n_vec;
int     errors;
int     transactions;
int     exp_trans;
int     cycles;
int     limit;
integer seed = 99;

// Valids of main b, main r, sub b and sub r at the last falling edge
logic [3:0] valid_now;
logic [3:0] valid_q;

// Second legal value after simultaneous writes to one address
bit                 alt_valid;
shr_bus_pkg::addr_t alt_addr;
shr_bus_pkg::data_t alt_data;

shr_top #(.RAM_AW(RAM_AW)) u_shr_top (.*);

initial begin
    clk = 1'b0;
    forever begin
        #4 clk = ~clk;
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
        $display("Timeout: run stopped after %0d cycles with a transaction still open", cycles);
        $display("TB FAILED");
        $finish;
    end
end

// Each rising valid is one response issued by the DUT
always @(negedge clk) begin
    valid_now = {sub_rvalid, sub_bvalid, main_rvalid, main_bvalid};
    for (int k = 0; k < 4; k++) begin
        if (valid_now[k] === 1'b1 && valid_q[k] !== 1'b1) begin
            transactions++;
        end
    end
    valid_q = valid_now;
end

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    if (got !== want) begin
        $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, want);
        errors++;
    end
endtask

task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       pstr;
    string       ostr;
    logic [31:0] a, d, e, r, b;
    fd = $fopen("tb/shr_vectors.txt", "r");
    if (fd == 0) begin
        $display("Could not open the vectors file tb/shr_vectors.txt");
        errors++;
        return;
    end
    while (!$feof(fd) && n_vec < MAX_VEC) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %s %h %h %h %h %h", pstr, ostr, a, d, e, r, b);
            if (n != 7) begin
                $display("Vector line could not be parsed: %s", line);
                errors++;
            end else begin
                v_port[n_vec]  = (pstr == "both") ? 2 : ((pstr == "sub") ? 1 : 0);
                v_wr[n_vec]    = (ostr == "write");
                v_addr[n_vec]  = a[12:0];
                v_wdata[n_vec] = d[7:0];
                v_exp[n_vec]   = e[7:0];
                v_resp[n_vec]  = r[1:0];
                v_blk[n_vec]   = b[0];
                exp_trans += (v_port[n_vec] == 2) ? 2 : 1;
                n_vec++;
            end
        end
    end
    $fclose(fd);
endtask

task automatic drive_request(input shr_ctrl_pkg::owner_e who, input bit wr,
                             input shr_bus_pkg::addr_t addr, input shr_bus_pkg::data_t wd,
                             input bit on);
    if (who == shr_ctrl_pkg::SUB) begin
        if (wr) begin
            sub_awaddr  <= addr;
            sub_wdata   <= wd;
            sub_awvalid <= on;
            sub_wvalid  <= on;
        end else begin
            sub_araddr  <= addr;
            sub_arvalid <= on;
        end
    end else begin
        if (wr) begin
            main_awaddr  <= addr;
            main_wdata   <= wd;
            main_awvalid <= on;
            main_wvalid  <= on;
        end else begin
            main_araddr  <= addr;
            main_arvalid <= on;
        end
    end
endtask

task automatic drive_ready(input shr_ctrl_pkg::owner_e who, input bit wr, input bit on);
    if (who == shr_ctrl_pkg::SUB) begin
        if (wr) begin
            sub_bready <= on;
        end else begin
            sub_rready <= on;
        end
    end else if (wr) begin
        main_bready <= on;
    end else begin
        main_rready <= on;
    end
endtask

function automatic logic accepted(input shr_ctrl_pkg::owner_e who, input bit wr);
    if (who == shr_ctrl_pkg::SUB) begin
        return wr ? (sub_awready && sub_wready) : sub_arready;
    end
    return wr ? (main_awready && main_wready) : main_arready;
endfunction

function automatic logic resp_valid(input shr_ctrl_pkg::owner_e who, input bit wr);
    if (who == shr_ctrl_pkg::SUB) begin
        return wr ? sub_bvalid : sub_rvalid;
    end
    return wr ? main_bvalid : main_rvalid;
endfunction

function automatic shr_bus_pkg::resp_t resp_code(input shr_ctrl_pkg::owner_e who, input bit wr);
    if (who == shr_ctrl_pkg::SUB) begin
        return wr ? sub_bresp : sub_rresp;
    end
    return wr ? main_bresp : main_rresp;
endfunction

function automatic shr_bus_pkg::data_t resp_data(input shr_ctrl_pkg::owner_e who);
    return (who == shr_ctrl_pkg::SUB) ? sub_rdata : main_rdata;
endfunction

// One AXI4-Lite transaction from request to response handshake
task automatic do_access(input shr_ctrl_pkg::owner_e who, input bit wr,
                         input shr_bus_pkg::addr_t addr, input shr_bus_pkg::data_t wd,
                         input int delay, output shr_bus_pkg::data_t rd,
                         output shr_bus_pkg::resp_t resp);
    string pfx;
    string vname;
    string cname;
    pfx = (who == shr_ctrl_pkg::SUB) ? "sub_" : "main_";
    if (wr) begin
        vname = {pfx, "bvalid"};
        cname = {pfx, "bresp"};
    end else begin
        vname = {pfx, "rvalid"};
        cname = {pfx, "rresp"};
    end
    @(posedge clk);
    drive_request(who, wr, addr, wd, 1'b1);
    @(negedge clk);
    while (!accepted(who, wr)) begin
        @(negedge clk);
    end
    @(posedge clk);
    drive_request(who, wr, addr, wd, 1'b0);
    @(negedge clk);
    while (!resp_valid(who, wr)) begin
        @(negedge clk);
    end
    rd   = resp_data(who);
    resp = resp_code(who, wr);
    // Master stalls for a few cycles and the response has to hold
    for (int n = 0; n <= delay; n++) begin
        @(posedge clk);
        if (n == delay) begin
            drive_ready(who, wr, 1'b1);
        end
        @(negedge clk);
        check_value(vname, 32'(resp_valid(who, wr)), 32'd1);
        check_value(cname, 32'(resp_code(who, wr)), 32'(resp));
        if (!wr) begin
            check_value({pfx, "rdata"}, 32'(resp_data(who)), 32'(rd));
        end
    end
    @(posedge clk);
    drive_ready(who, wr, 1'b0);
    @(negedge clk);
    // Exactly one response per transaction
    check_value(vname, 32'(resp_valid(who, wr)), 32'd0);
endtask

task automatic check_result(input shr_ctrl_pkg::owner_e who, input int i,
                            input shr_bus_pkg::addr_t addr, input shr_bus_pkg::data_t rd,
                            input shr_bus_pkg::resp_t rs);
    string              pfx;
    shr_bus_pkg::data_t want;
    pfx = (who == shr_ctrl_pkg::SUB) ? "sub_" : "main_";
    if (v_wr[i]) begin
        check_value({pfx, "bresp"}, 32'(rs), 32'(v_resp[i]));
        if (v_port[i] != 2 && addr == alt_addr) begin
            alt_valid = 1'b0;
        end
    end else begin
        check_value({pfx, "rresp"}, 32'(rs), 32'(v_resp[i]));
        want = v_exp[i];
        if (alt_valid && addr == alt_addr && rd == alt_data) begin
            want = alt_data;
        end
        check_value({pfx, "rdata"}, 32'(rd), 32'(want));
    end
endtask

task automatic expect_sub_idle();
    check_value("sub_bvalid", 32'(sub_bvalid), 32'd0);
    check_value("sub_rvalid", 32'(sub_rvalid), 32'd0);
endtask

task automatic run_line(input int i);
    shr_bus_pkg::data_t rd_main;
    shr_bus_pkg::data_t rd_sub;
    shr_bus_pkg::resp_t rs_main;
    shr_bus_pkg::resp_t rs_sub;
    shr_bus_pkg::addr_t sub_addr;
    shr_bus_pkg::data_t sub_wd;
    int                 dly_main;
    int                 dly_sub;
    bit                 main_done;
    dly_main  = $unsigned($random(seed)) % 4;
    dly_sub   = $unsigned($random(seed)) % 4;
    main_done = 1'b0;
    @(posedge clk);
    sub_block <= v_blk[i];
    if (v_port[i] == 0) begin
        do_access(shr_ctrl_pkg::MAIN, v_wr[i], v_addr[i], v_wdata[i], dly_main,
                  rd_main, rs_main);
        check_result(shr_ctrl_pkg::MAIN, i, v_addr[i], rd_main, rs_main);
    end else if (v_port[i] == 1) begin
        do_access(shr_ctrl_pkg::SUB, v_wr[i], v_addr[i], v_wdata[i], dly_sub, rd_sub, rs_sub);
        check_result(shr_ctrl_pkg::SUB, i, v_addr[i], rd_sub, rs_sub);
    end else begin
        // Sub side of a both-write lands at addr plus offset with inverted data
        sub_addr = v_wr[i] ? v_addr[i] + 13'(v_exp[i]) : v_addr[i];
        sub_wd   = ~v_wdata[i];
        fork
            begin
                do_access(shr_ctrl_pkg::MAIN, v_wr[i], v_addr[i], v_wdata[i], dly_main,
                          rd_main, rs_main);
                main_done = 1'b1;
            end
            do_access(shr_ctrl_pkg::SUB, v_wr[i], sub_addr, sub_wd, dly_sub, rd_sub, rs_sub);
            if (v_blk[i]) begin
                // Sub held off while main finishes, then released
                while (!main_done) begin
                    @(negedge clk);
                    expect_sub_idle();
                end
                repeat (4) begin
                    @(negedge clk);
                    expect_sub_idle();
                end
                @(posedge clk);
                sub_block <= 1'b0;
            end
        join
        check_result(shr_ctrl_pkg::MAIN, i, v_addr[i], rd_main, rs_main);
        check_result(shr_ctrl_pkg::SUB, i, sub_addr, rd_sub, rs_sub);
        if (v_wr[i] && sub_addr == v_addr[i]) begin
            alt_valid = 1'b1;
            alt_addr  = sub_addr;
            alt_data  = sub_wd;
        end
    end
endtask

initial begin
    rst_n        = 1'b0;
    sub_block    = 1'b0;
    main_awaddr  = '0;
    main_awvalid = 1'b0;
    main_wdata   = '0;
    main_wvalid  = 1'b0;
    main_bready  = 1'b0;
    main_araddr  = '0;
    main_arvalid = 1'b0;
    main_rready  = 1'b0;
    sub_awaddr   = '0;
    sub_awvalid  = 1'b0;
    sub_wdata    = '0;
    sub_wvalid   = 1'b0;
    sub_bready   = 1'b0;
    sub_araddr   = '0;
    sub_arvalid  = 1'b0;
    sub_rready   = 1'b0;
    load_vectors();
    limit = n_vec * 40 + 200;
    repeat (4) begin
        @(posedge clk);
    end
    rst_n <= 1'b1;
    for (int i = 0; i < n_vec; i++) begin
        run_line(i);
    end
    check_value("transactions", transactions, exp_trans);
    $display("Errors: %0d, transactions: %0d of %0d", errors, transactions, exp_trans);
    if (errors == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== tb/shr_vectors.txt ====
# port op addr wdata exp_rdata exp_resp sub_block, numbers in hex
# both write: sub writes ~wdata at addr + exp_rdata; both read: both ports read addr
main write 0000 11 00 0 0
main read  0000 00 11 0 0
sub  write 07ff 22 00 0 0
sub  read  07ff 00 22 0 0
main write 07ff 33 00 0 0
main read  07ff 00 33 0 0
sub  write 0000 44 00 0 0
sub  read  0000 00 44 0 0
main write 0123 5a 00 0 0
sub  read  0123 00 5a 0 0
sub  write 0456 a7 00 0 0
main read  0456 00 a7 0 0
both write 0200 c3 01 0 0
main read  0201 00 3c 0 0
sub  read  0200 00 c3 0 0
both write 0300 96 00 0 0
main read  0300 00 96 0 0
sub  read  0300 00 96 0 0
both read  0200 00 c3 0 0
both write 0400 e1 01 0 1
main read  0401 00 1e 0 0
sub  read  0400 00 e1 0 0
main read  0123 00 5a 0 1
main write 0800 ff 00 2 0
main read  0800 00 00 2 0
sub  write 1fff ff 00 2 0
sub  read  1000 00 00 2 0
main read  0000 00 44 0 0
sub  read  07ff 00 33 0 0

// ==== vlog.f ====
source/shr_bus_pkg.sv
source/shr_ctrl_pkg.sv
source/shr_ram.sv
source/shr_arbiter.sv
source/shr_axil_port.sv
source/shr_top.sv
tb/shr_tb.sv
